// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing --assert --timescale 1ns/100ps
TOP   = tb_mem_subsys
FLIST = project.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

// ==== logic/axi_sram.sv ====
`timescale 1ns/100ps
`default_nettype none

module axi_sram import lsu_pkg::*; #(
    parameter int sram_words = 1024
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              awvalid,
    output logic              awready,
    input  logic [addr_w-1:0] awaddr,
    input  logic [2:0]        awsize,
    input  logic              wvalid,
    output logic              wready,
    input  logic [data_w-1:0] wdata,
    input  logic [3:0]        wstrb,
    input  logic              wlast,
    output logic              bvalid,
    input  logic              bready,
    output logic [1:0]        bresp,
    input  logic              arvalid,
    output logic              arready,
    input  logic [addr_w-1:0] araddr,
    input  logic [2:0]        arsize,
    output logic              rvalid,
    input  logic              rready,
    output logic [data_w-1:0] rdata,
    output logic [1:0]        rresp
);

    localparam int                idx_w    = $clog2(sram_words);
    localparam logic [addr_w-1:0] top_addr = addr_w'(sram_words * 4);

    logic [data_w-1:0] mem [sram_words];
    logic              aw_seen;
    logic [addr_w-1:0] w_addr;
    logic [2:0]        w_size;
    logic              w_bad;
    logic              ar_bad;

    // single beat only, no wider than a word
    assign ar_bad = araddr >= top_addr || arsize > 3'd2;
    assign w_bad  = w_addr >= top_addr || w_size > 3'd2 || !wlast;

    always_ff @(posedge clk) begin
        if (reset) begin
            awready <= 1'b0;
            arready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            aw_seen <= 1'b0;
        end else if (awvalid && awready) begin
            awready <= 1'b0;
            arready <= 1'b0;
            wready  <= 1'b1;
            aw_seen <= 1'b1;
        end else if (arvalid && arready) begin
            awready <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b1;
        end else if (wvalid && wready) begin
            wready <= 1'b0;
            bvalid <= 1'b1;
        end else if ((bvalid && bready) || (rvalid && rready)) begin
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            aw_seen <= 1'b0;
            awready <= 1'b1;
            arready <= 1'b1;
        end else if (!aw_seen && !rvalid) begin
            // first arm after reset
            awready <= 1'b1;
            arready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            w_addr <= awaddr;
            w_size <= awsize;
        end
        if (arvalid && arready) begin
            rdata <= ar_bad ? '0 : mem[araddr[idx_w+1:2]];
            rresp <= ar_bad ? axi_resp_slverr : axi_resp_okay;
        end
        if (wvalid && wready) begin
            bresp <= w_bad ? axi_resp_slverr : axi_resp_okay;
            for (int i = 0; i < 4; i++) begin
                if (!w_bad && wstrb[i]) mem[w_addr[idx_w+1:2]][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    a_w_after_aw: assert property (@(posedge clk) disable iff (reset)
        wvalid |-> aw_seen);

endmodule

`default_nettype wire

// ==== logic/clint_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module clint_timer import lsu_pkg::*; #(
    parameter logic [addr_w-1:0] clint_base = 32'ha0000048
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              tvalid,
    input  logic [addr_w-1:0] taddr,
    output logic              tready,
    output logic [data_w-1:0] tdata,
    output logic [1:0]        tresp
);

    logic [63:0]       mtime;
    logic [addr_w-1:0] toff;

    assign toff = taddr - clint_base;

    always_ff @(posedge clk) begin
        if (reset) begin
            mtime  <= '0;
            tready <= 1'b0;
        end else begin
            mtime  <= mtime + 64'd1;
            // one-cycle ready pulse per request
            tready <= tvalid && !tready;
        end
    end

    // offset 4 selects the upper half
    always_ff @(posedge clk) begin
        tdata <= toff[2] ? mtime[63:32] : mtime[31:0];
        tresp <= (toff[1:0] == 2'b00) ? axi_resp_okay : axi_resp_slverr;
    end

    // the lsu decode only routes window addresses here
    a_in_window: assert property (@(posedge clk) disable iff (reset)
        tvalid |-> (toff < addr_w'(8)));

endmodule

`default_nettype wire

// ==== logic/lsu.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu import lsu_pkg::*; #(
    parameter logic [addr_w-1:0] clint_base = 32'ha0000048
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              req,
    input  logic              we,
    input  logic              sign,
    input  mem_size_t         size,
    input  logic [addr_w-1:0] addr,
    input  logic [data_w-1:0] wdata,
    output logic [data_w-1:0] rdata,
    output logic              done,
    output logic              err,
    output logic              busy,
    output logic              awvalid,
    input  logic              awready,
    output logic [addr_w-1:0] awaddr,
    output logic [2:0]        awsize,
    output logic              wvalid,
    input  logic              wready,
    output logic [data_w-1:0] wdata_m,
    output logic [3:0]        wstrb,
    output logic              wlast,
    input  logic              bvalid,
    output logic              bready,
    input  logic [1:0]        bresp,
    output logic              arvalid,
    input  logic              arready,
    output logic [addr_w-1:0] araddr,
    output logic [2:0]        arsize,
    input  logic              rvalid,
    output logic              rready,
    input  logic [data_w-1:0] rdata_m,
    input  logic [1:0]        rresp
);

    typedef enum logic [2:0] {
        st_idle, st_ar, st_r, st_aw, st_w, st_b, st_tmr, st_terr
    } lsu_state_t;

    lsu_state_t        state;
    logic [addr_w-1:0] req_addr;
    logic              req_we;
    logic              req_sign;
    mem_size_t         req_size;
    logic [data_w-1:0] req_wdata;
    logic [data_w-1:0] rword;
    logic              in_window;
    logic              tvalid;
    logic              tready;
    logic [data_w-1:0] tdata;
    logic [1:0]        tresp;

    // wraps below the base, so one compare covers the window
    assign in_window = (addr - clint_base) < addr_w'(8);
    assign busy      = state != st_idle;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            done  <= 1'b0;
            err   <= 1'b0;
        end else begin
            done <= 1'b0;
            err  <= 1'b0;
            case (state)
                st_idle: if (req) begin
                    if (in_window) state <= we ? st_terr : st_tmr;
                    else           state <= we ? st_aw : st_ar;
                end
                st_ar: if (arready) state <= st_r;
                st_r: if (rvalid) begin
                    state <= st_idle;
                    done  <= 1'b1;
                    err   <= rresp != axi_resp_okay;
                end
                st_aw: if (awready) state <= st_w;
                st_w:  if (wready) state <= st_b;
                st_b: if (bvalid) begin
                    state <= st_idle;
                    done  <= 1'b1;
                    err   <= bresp != axi_resp_okay;
                end
                st_tmr: if (tready) begin
                    state <= st_idle;
                    done  <= 1'b1;
                    err   <= tresp != axi_resp_okay;
                end
                // mtime is read-only here
                st_terr: begin
                    state <= st_idle;
                    done  <= 1'b1;
                    err   <= 1'b1;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            req_addr  <= addr;
            req_we    <= we;
            req_sign  <= sign;
            req_size  <= size;
            req_wdata <= wdata;
        end
        if (rvalid && rready) rword <= rdata_m;
        if (tvalid && tready) rword <= tdata;
    end

    assign awvalid = state == st_aw;
    assign wvalid  = state == st_w;
    assign wlast   = state == st_w;
    assign bready  = state == st_b && req_we;
    assign arvalid = state == st_ar;
    assign rready  = state == st_r && !req_we;
    assign tvalid  = state == st_tmr;
    assign awaddr  = req_addr;
    assign araddr  = req_addr;
    assign awsize  = {1'b0, req_size};
    assign arsize  = {1'b0, req_size};

    lsu_align i_lsu_align (
        .size(req_size), .sign(req_sign), .offset(req_addr[1:0]),
        .wdata(req_wdata), .rword(rword),
        .wlane(wdata_m), .wstrb(wstrb), .rdata(rdata)
    );

    clint_timer #(.clint_base(clint_base)) i_clint_timer (
        .clk(clk), .reset(reset), .tvalid(tvalid), .taddr(req_addr),
        .tready(tready), .tdata(tdata), .tresp(tresp)
    );

    a_aw_stable: assert property (@(posedge clk) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(awaddr));
    a_ar_stable: assert property (@(posedge clk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr));
    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done);

endmodule

`default_nettype wire

// ==== logic/lsu_align.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_align import lsu_pkg::*; (
    input  mem_size_t         size,
    input  logic              sign,
    input  logic [1:0]        offset,
    input  logic [data_w-1:0] wdata,
    input  logic [data_w-1:0] rword,
    output logic [data_w-1:0] wlane,
    output logic [3:0]        wstrb,
    output logic [data_w-1:0] rdata
);

    logic [4:0]        shamt;
    logic [data_w-1:0] rshift;

    assign shamt = {offset, 3'b000};

    // store data moves up to its byte lane
    assign wlane = wdata << shamt;

    always_comb begin
        case (size)
            size_byte: wstrb = 4'b0001 << offset;
            size_half: wstrb = offset[1] ? 4'b1100 : 4'b0011;
            size_word: wstrb = 4'b1111;
            default:   wstrb = 4'b0000;
        endcase
    end

    // load data comes back down to bit 0
    assign rshift = rword >> shamt;

    always_comb begin
        case (size)
            size_byte: begin
                rdata = {{24{sign & rshift[7]}}, rshift[7:0]};
            end
            size_half: begin
                rdata = {{16{sign & rshift[15]}}, rshift[15:0]};
            end
            size_word: begin
                rdata = rshift;
            end
            default: begin
                rdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    // bus widths for the core side and the AXI port
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // access size as issued by the core
    // the same encoding lands in AxSIZE
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } mem_size_t;

    // AXI response codes in use
    localparam logic [1:0] axi_resp_okay   = 2'b00;
    localparam logic [1:0] axi_resp_slverr = 2'b10;

endpackage

`default_nettype wire

// ==== logic/mem_subsys.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_subsys import lsu_pkg::*; #(
    parameter logic [addr_w-1:0] clint_base = 32'ha0000048,
    parameter int                sram_words = 1024
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              req,
    input  logic              we,
    input  logic              sign,
    input  mem_size_t         size,
    input  logic [addr_w-1:0] addr,
    input  logic [data_w-1:0] wdata,
    output logic [data_w-1:0] rdata,
    output logic              done,
    output logic              err,
    output logic              busy
);

    // AXI4 links between the unit and the memory
    logic              awvalid, awready, wvalid, wready, wlast;
    logic              bvalid, bready, arvalid, arready, rvalid, rready;
    logic [addr_w-1:0] awaddr, araddr;
    logic [2:0]        awsize, arsize;
    logic [data_w-1:0] wdata_m, rdata_m;
    logic [3:0]        wstrb;
    logic [1:0]        bresp, rresp;

    lsu #(.clint_base(clint_base)) i_lsu (
        .clk(clk), .reset(reset), .req(req), .we(we), .sign(sign), .size(size),
        .addr(addr), .wdata(wdata), .rdata(rdata), .done(done), .err(err), .busy(busy),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr), .awsize(awsize),
        .wvalid(wvalid), .wready(wready), .wdata_m(wdata_m), .wstrb(wstrb), .wlast(wlast),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr), .arsize(arsize),
        .rvalid(rvalid), .rready(rready), .rdata_m(rdata_m), .rresp(rresp)
    );

    axi_sram #(.sram_words(sram_words)) i_axi_sram (
        .clk(clk), .reset(reset),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr), .awsize(awsize),
        .wvalid(wvalid), .wready(wready), .wdata(wdata_m), .wstrb(wstrb), .wlast(wlast),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr), .arsize(arsize),
        .rvalid(rvalid), .rready(rready), .rdata(rdata_m), .rresp(rresp)
    );

endmodule

`default_nettype wire

// ==== project.f ====
logic/lsu_pkg.sv
logic/lsu_align.sv
logic/clint_timer.sv
logic/lsu.sv
logic/axi_sram.sv
logic/mem_subsys.sv
sim/tb_clock.sv
sim/tb_mem_subsys.sv

// ==== sim/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int period_ns = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== sim/tb_mem_subsys.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mem_subsys import lsu_pkg::*; ();

    localparam logic [31:0] clint_base = 32'ha0000048;
    localparam int          sram_words = 1024;
    localparam logic [31:0] top_addr   = 32'(sram_words * 4);
    localparam int          n_words    = 16;
    // word fill, lane stores, lane loads, timer, out of range
    localparam int n_access = 2 * n_words + 48 + 26 + (6 + n_words) + (2 + n_words);
    localparam int limit    = 200 * n_access + 40;

    logic              clk, reset, req, we, sign, done, err, busy;
    mem_size_t         size;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata, rdata;

    logic [7:0]  model [sram_words * 4];
    logic [31:0] wlist [n_words];
    logic [31:0] rng, r, exp_rdata, last_rdata, last_mtime;
    logic        exp_err, exp_data, exp_rise, started;
    int          errors, test_errors, test_no, n_pass, n_fail;

    tb_clock i_tb_clock (.clk(clk));

    mem_subsys #(.clint_base(clint_base), .sram_words(sram_words)) i_mem_subsys (
        .clk(clk), .reset(reset), .req(req), .we(we), .sign(sign), .size(size),
        .addr(addr), .wdata(wdata), .rdata(rdata), .done(done), .err(err), .busy(busy)
    );

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] a);
        logic [11:0] i;
        i = {a[11:2], 2'b00};
        return {model[i + 12'd3], model[i + 12'd2], model[i + 12'd1], model[i]};
    endfunction

    task automatic flag(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    // one request, then wait for done and one more edge so the checks see it
    task automatic access(input logic w, input logic s, input mem_size_t sz,
            input logic [31:0] a, input logic [31:0] d, input logic chk,
            input logic [31:0] exp_d, input logic exp_e, input logic rise);
        exp_data  = chk;
        exp_rise  = rise;
        exp_rdata = exp_d;
        exp_err   = exp_e;
        req       = 1'b1;
        we        = w;
        sign      = s;
        size      = sz;
        addr      = a;
        wdata     = d;
        started   = 1'b1;
        @(posedge clk);
        #1;
        req = 1'b0;
        while (!done) begin
            @(posedge clk);
            #1;
        end
        last_rdata = rdata;
        @(posedge clk);
        #1;
    endtask

    task automatic store(input mem_size_t sz, input logic [31:0] a, input logic [31:0] d);
        logic [11:0] i;
        i = a[11:0];
        access(1'b1, 1'b0, sz, a, d, 1'b0, '0, 1'b0, 1'b0);
        model[i] = d[7:0];
        if (sz != size_byte) model[i + 12'd1] = d[15:8];
        if (sz == size_word) begin
            model[i + 12'd2] = d[23:16];
            model[i + 12'd3] = d[31:24];
        end
    endtask

    task automatic load(input mem_size_t sz, input logic s, input logic [31:0] a);
        logic [11:0] i;
        logic [15:0] h;
        logic [31:0] e;
        i = a[11:0];
        h = {model[i + 12'd1], model[i]};
        case (sz)
            size_byte: e = {{24{s & h[7]}}, h[7:0]};
            size_half: e = {{16{s & h[15]}}, h};
            default:   e = model_word(a);
        endcase
        access(1'b0, s, sz, a, '0, 1'b1, e, 1'b0, 1'b0);
    endtask

    task automatic check_all();
        foreach (wlist[k]) load(size_word, 1'b0, wlist[k]);
    endtask

    task automatic finish_test(input string name);
        test_no++;
        if (errors == test_errors) begin
            n_pass++;
            $display("test %0d %s: ok", test_no, name);
        end else begin
            n_fail++;
            $display("test %0d %s: failed with %0d errors", test_no, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    a_quiet: assert property (@(posedge clk) disable iff (reset)
        !started |-> !done && !err && !busy)
        else flag("done, err or busy went high before any request");
    a_err: assert property (@(posedge clk) disable iff (reset) done |-> err == exp_err)
        else flag($sformatf("error: err 0x%h expected 0x%h at addr 0x%h",
            $sampled(err), exp_err, addr));
    a_rdata: assert property (@(posedge clk) disable iff (reset)
        done && exp_data |-> rdata == exp_rdata)
        else flag($sformatf("error: rdata 0x%h expected 0x%h at addr 0x%h",
            $sampled(rdata), exp_rdata, addr));
    a_rise: assert property (@(posedge clk) disable iff (reset)
        done && exp_rise |-> rdata > last_mtime)
        else flag($sformatf("error: rdata 0x%h not above last mtime 0x%h",
            $sampled(rdata), last_mtime));

    initial begin
        rng = 32'hd117;
        {req, we, sign, started, exp_err, exp_data, exp_rise} = '0;
        size = size_word;
        addr = '0;
        wdata = '0;
        exp_rdata = '0;
        last_mtime = '0;
        {errors, test_errors, test_no, n_pass, n_fail} = '0;
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (20) @(posedge clk);
        #1;
        finish_test("idle after reset");

        for (int k = 0; k < n_words; k++) begin
            r = next_rand();
            wlist[k] = {20'd0, r[11:2], 2'b00};
            store(size_word, wlist[k], next_rand());
        end
        check_all();
        finish_test("word store and load");

        // each lane store read back on its own, halves at aligned offsets
        for (int k = 0; k < 4; k++) begin
            for (int off = 0; off < 4; off++) begin
                store(size_byte, wlist[k] + 32'(off), next_rand());
                load(size_word, 1'b0, wlist[k]);
            end
            store(size_half, wlist[k], next_rand());
            load(size_word, 1'b0, wlist[k]);
            store(size_half, wlist[k] + 32'd2, next_rand());
            load(size_word, 1'b0, wlist[k]);
        end
        finish_test("byte and half stores");

        // one word with every lane negative, one with none
        store(size_word, wlist[0], next_rand() | 32'h80808080);
        store(size_word, wlist[1], next_rand() & 32'h7f7f7f7f);
        for (int k = 0; k < 2; k++) begin
            for (int s = 0; s < 2; s++) begin
                for (int off = 0; off < 4; off++) load(size_byte, s[0], wlist[k] + 32'(off));
                load(size_half, s[0], wlist[k]);
                load(size_half, s[0], wlist[k] + 32'd2);
            end
        end
        finish_test("byte and half loads");

        for (int n = 0; n < 4; n++) begin
            access(1'b0, 1'b0, size_word, clint_base, '0, 1'b0, '0, 1'b0, 1'b1);
            last_mtime = last_rdata;
        end
        access(1'b0, 1'b0, size_word, clint_base + 32'd4, '0, 1'b1, '0, 1'b0, 1'b0);
        access(1'b1, 1'b0, size_word, clint_base, next_rand(), 1'b0, '0, 1'b1, 1'b0);
        check_all();
        finish_test("timer window");

        // aliases a written word if the range check were missing
        access(1'b0, 1'b0, size_word, top_addr + wlist[2], '0, 1'b0, '0, 1'b1, 1'b0);
        access(1'b1, 1'b0, size_word, top_addr + wlist[3], next_rand(), 1'b0, '0, 1'b1, 1'b0);
        check_all();
        finish_test("out of range");

        $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
        if (n_fail == 0 && errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (limit) @(posedge clk);
        $display("timeout: run still going after %0d cycles", limit);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
